// File: hdl/d_cache.sv
`timescale 1ns/1ps

module d_cache
    import nand_cpu_pkg::*;
#(
    parameter int addr_bits   = 6,
    parameter int block_words = 4,
    parameter int cache_lines = 4,
    localparam int off_bits   = $clog2(block_words),
    localparam int blk_bits   = addr_bits - off_bits,
    localparam int idx_bits   = $clog2(cache_lines),
    localparam int tag_bits   = blk_bits - idx_bits
) (
    input  logic                    clk,
    input  logic                    n_rst,

    input  logic                    dc_req,
    input  mem_op_t                 dc_op,
    input  logic [addr_bits-1:0]    dc_addr,
    input  word_t                   dc_wdata,
    output logic                    dc_ack,
    output word_t                   dc_rdata,

    output logic                    md_req,
    output mem_op_t                 md_op,
    output logic [blk_bits-1:0]     md_addr,
    output word_t [block_words-1:0] md_wblock,
    input  logic                    md_ack,
    input  word_t                   md_rdata,
    input  logic                    md_rvalid
);

    logic [cache_lines-1:0]  valid;
    logic [cache_lines-1:0]  dirty;
    logic [tag_bits-1:0]     tags [cache_lines];
    word_t [block_words-1:0] lines [cache_lines];
    cache_state_t            state;
    logic [off_bits-1:0]     refill_beat;
    logic [off_bits-1:0]     off;
    logic [idx_bits-1:0]     idx;
    logic [tag_bits-1:0]     req_tag;
    logic                    hit;
    logic                    start;
    logic                    refill_end;

    assign off        = dc_addr[off_bits-1:0];
    assign idx        = dc_addr[off_bits +: idx_bits];
    assign req_tag    = dc_addr[addr_bits-1 -: tag_bits];
    assign hit        = valid[idx] && tags[idx] == req_tag;
    assign start      = state == C_IDLE && dc_req && !md_ack;
    assign refill_end = state == C_REFILL && md_ack;

    // ------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state  <= C_IDLE;
            valid  <= '0;
            dirty  <= '0;
            dc_ack <= 1'b0;
            md_req <= 1'b0;
        end else begin
            case (state)
                C_IDLE: begin
                    if (start && hit) begin
                        if (dc_op == OP_STORE) begin
                            dirty[idx] <= 1'b1;
                        end
                        dc_ack <= 1'b1;
                        state  <= C_DONE;
                    end else if (start) begin
                        md_req <= 1'b1;
                        state  <= (valid[idx] && dirty[idx]) ? C_WRITEBACK : C_REFILL;
                    end
                end
                C_WRITEBACK: begin
                    // full handshake for the old block, then ask for the new one
                    if (md_req && md_ack) begin
                        md_req <= 1'b0;
                    end else if (!md_req && !md_ack) begin
                        md_req <= 1'b1;
                        state  <= C_REFILL;
                    end
                end
                C_REFILL: begin
                    if (md_ack) begin
                        md_req     <= 1'b0;
                        valid[idx] <= 1'b1;
                        dirty[idx] <= dc_op == OP_STORE;
                        dc_ack     <= 1'b1;
                        state      <= C_DONE;
                    end
                end
                C_DONE: begin
                    if (!dc_req) begin
                        dc_ack <= 1'b0;
                        state  <= C_IDLE;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // lines and memory request payload
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (state == C_IDLE) begin
            // victim block address if dirty, else the missing block
            md_op       <= (valid[idx] && dirty[idx]) ? OP_STORE : OP_LOAD;
            md_addr     <= (valid[idx] && dirty[idx]) ? {tags[idx], idx}
                                                      : dc_addr[addr_bits-1:off_bits];
            md_wblock   <= lines[idx];
            refill_beat <= '0;
        end
        if (state == C_WRITEBACK && !md_req && !md_ack) begin
            md_op   <= OP_LOAD;
            md_addr <= dc_addr[addr_bits-1:off_bits];
        end
        if (state == C_REFILL && md_rvalid) begin
            lines[idx][refill_beat] <= md_rdata;
            refill_beat             <= refill_beat + 1'b1;
        end
        if (refill_end) begin
            tags[idx] <= req_tag;
        end
        // store hit, or merge after write-allocate
        if (dc_op == OP_STORE && ((start && hit) || refill_end)) begin
            lines[idx][off] <= dc_wdata;
        end
        if (state != C_DONE) begin
            dc_rdata <= lines[idx][off];
        end
    end

    a_md_req_held: assert property (@(posedge clk) disable iff (!n_rst)
        md_req && !md_ack |=> md_req);

endmodule

// File: hdl/i_cache.sv
`timescale 1ns/1ps

module i_cache
    import nand_cpu_pkg::*;
#(
    parameter int addr_bits   = 6,
    parameter int block_words = 4,
    parameter int cache_lines = 4,
    localparam int off_bits   = $clog2(block_words),
    localparam int blk_bits   = addr_bits - off_bits,
    localparam int idx_bits   = $clog2(cache_lines),
    localparam int tag_bits   = blk_bits - idx_bits
) (
    input  logic                 clk,
    input  logic                 n_rst,

    input  logic                 if_req,
    input  logic [addr_bits-1:0] if_addr,
    output logic                 if_ack,
    output word_t                if_data,

    output logic                 mi_req,
    output logic [blk_bits-1:0]  mi_addr,
    input  logic                 mi_ack,
    input  word_t                mi_rdata,
    input  logic                 mi_rvalid
);

    logic [cache_lines-1:0]  valid;
    logic [tag_bits-1:0]     tags [cache_lines];
    word_t [block_words-1:0] lines [cache_lines];
    cache_state_t            state;
    logic [off_bits-1:0]     refill_beat;
    logic [off_bits-1:0]     off;
    logic [idx_bits-1:0]     idx;
    logic [tag_bits-1:0]     req_tag;
    logic                    hit;

    assign off     = if_addr[off_bits-1:0];
    assign idx     = if_addr[off_bits +: idx_bits];
    assign req_tag = if_addr[addr_bits-1 -: tag_bits];
    assign hit     = valid[idx] && tags[idx] == req_tag;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state  <= C_IDLE;
            valid  <= '0;
            if_ack <= 1'b0;
            mi_req <= 1'b0;
        end else begin
            case (state)
                C_IDLE: begin
                    // memory ack of the last refill must be gone
                    if (if_req && !mi_ack) begin
                        if (hit) begin
                            if_ack <= 1'b1;
                            state  <= C_DONE;
                        end else begin
                            mi_req <= 1'b1;
                            state  <= C_REFILL;
                        end
                    end
                end
                C_REFILL: begin
                    if (mi_ack) begin
                        mi_req     <= 1'b0;
                        valid[idx] <= 1'b1;
                        if_ack     <= 1'b1;
                        state      <= C_DONE;
                    end
                end
                C_DONE: begin
                    if (!if_req) begin
                        if_ack <= 1'b0;
                        state  <= C_IDLE;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // line fill and result word
    always_ff @(posedge clk) begin
        if (state == C_IDLE) begin
            mi_addr     <= if_addr[addr_bits-1:off_bits];
            refill_beat <= '0;
        end
        if (state == C_REFILL && mi_rvalid) begin
            lines[idx][refill_beat] <= mi_rdata;
            refill_beat             <= refill_beat + 1'b1;
        end
        if (state == C_REFILL && mi_ack) begin
            tags[idx] <= req_tag;
        end
        if (state != C_DONE) begin
            if_data <= lines[idx][off];
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!n_rst)
        $past(if_req) && if_req |-> $stable(if_addr));

endmodule

// File: hdl/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem
    import nand_cpu_pkg::*;
#(
    parameter int addr_bits   = 6,
    parameter int block_words = 4,
    parameter int cache_lines = 4,
    localparam int blk_bits   = addr_bits - $clog2(block_words)
) (
    input  logic                 clk,
    input  logic                 n_rst,

    input  logic                 if_req,
    input  logic [addr_bits-1:0] if_addr,
    output logic                 if_ack,
    output word_t                if_data,

    input  logic                 dc_req,
    input  mem_op_t              dc_op,
    input  logic [addr_bits-1:0] dc_addr,
    input  word_t                dc_wdata,
    output logic                 dc_ack,
    output word_t                dc_rdata
);

    // icache to memory
    logic                    mi_req;
    logic [blk_bits-1:0]     mi_addr;
    logic                    mi_ack;
    word_t                   mi_rdata;
    logic                    mi_rvalid;

    // dcache to memory
    logic                    md_req;
    mem_op_t                 md_op;
    logic [blk_bits-1:0]     md_addr;
    word_t [block_words-1:0] md_wblock;
    logic                    md_ack;
    word_t                   md_rdata;
    logic                    md_rvalid;

    i_cache #(
        .addr_bits   (addr_bits),
        .block_words (block_words),
        .cache_lines (cache_lines)
    ) u_i_cache (
        .clk, .n_rst,
        .if_req, .if_addr, .if_ack, .if_data,
        .mi_req, .mi_addr, .mi_ack, .mi_rdata, .mi_rvalid
    );

    d_cache #(
        .addr_bits   (addr_bits),
        .block_words (block_words),
        .cache_lines (cache_lines)
    ) u_d_cache (
        .clk, .n_rst,
        .dc_req, .dc_op, .dc_addr, .dc_wdata, .dc_ack, .dc_rdata,
        .md_req, .md_op, .md_addr, .md_wblock, .md_ack, .md_rdata, .md_rvalid
    );

    memory #(
        .addr_bits   (addr_bits),
        .block_words (block_words)
    ) u_memory (
        .clk, .n_rst,
        .mi_req, .mi_addr, .mi_ack, .mi_rdata, .mi_rvalid,
        .md_req, .md_op, .md_addr, .md_wblock, .md_ack, .md_rdata, .md_rvalid
    );

endmodule

// File: hdl/memory.sv
`timescale 1ns/1ps

module memory
    import nand_cpu_pkg::*;
#(
    parameter int addr_bits   = 6,
    parameter int block_words = 4,
    localparam int off_bits   = $clog2(block_words),
    localparam int blk_bits   = addr_bits - off_bits
) (
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            mi_req,
    input  logic [blk_bits-1:0]             mi_addr,
    output logic                            mi_ack,
    output word_t                           mi_rdata,
    output logic                            mi_rvalid,

    input  logic                            md_req,
    input  mem_op_t                         md_op,
    input  logic [blk_bits-1:0]             md_addr,
    input  word_t [block_words-1:0]         md_wblock,
    output logic                            md_ack,
    output word_t                           md_rdata,
    output logic                            md_rvalid
);

    word_t               mem [2**addr_bits];
    mem_state_t          state;
    mem_state_t          next_state;
    logic [off_bits-1:0] beat;
    logic [blk_bits-1:0] blk_addr;
    logic                serve_d;
    logic                serve_wr;
    word_t               beat_data;

    initial begin
        $readmemh("mem_init.hex", mem);
    end

    // one beat register feeds both read ports, rvalid tells them apart
    assign mi_rdata = beat_data;
    assign md_rdata = beat_data;

    // ------------------------------------------------------------------
    // port selection and sequencing
    // ------------------------------------------------------------------

    always_comb begin
        next_state = state;
        case (state)
            MS_READY: begin
                // icache first
                if (mi_req) begin
                    next_state = MS_I_READ;
                end else if (md_req && md_op == OP_STORE) begin
                    next_state = MS_D_WRITE;
                end else if (md_req) begin
                    next_state = MS_D_READ;
                end
            end
            MS_I_READ, MS_D_WRITE, MS_D_READ: begin
                if (&beat) begin
                    next_state = MS_RELEASE;
                end
            end
            MS_D_HOLD: begin
                // only the refill that follows the eviction
                if (md_req && md_op == OP_LOAD) begin
                    next_state = MS_D_READ;
                end
            end
            MS_RELEASE: begin
                if (!(serve_d ? md_req : mi_req)) begin
                    next_state = serve_wr ? MS_D_HOLD : MS_READY;
                end
            end
            default: next_state = MS_READY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state     <= MS_READY;
            beat      <= '0;
            serve_d   <= 1'b0;
            serve_wr  <= 1'b0;
            mi_ack    <= 1'b0;
            md_ack    <= 1'b0;
            mi_rvalid <= 1'b0;
            md_rvalid <= 1'b0;
        end else begin
            state     <= next_state;
            mi_ack    <= state == MS_RELEASE && !serve_d && mi_req;
            md_ack    <= state == MS_RELEASE && serve_d && md_req;
            mi_rvalid <= state == MS_I_READ;
            md_rvalid <= state == MS_D_READ;
            // wraps back to zero after the last beat
            if (state == MS_I_READ || state == MS_D_WRITE || state == MS_D_READ) begin
                beat <= beat + 1'b1;
            end else begin
                beat <= '0;
            end
            if (state == MS_READY) begin
                serve_d  <= !mi_req;
                serve_wr <= !mi_req && md_op == OP_STORE;
            end else if (state == MS_D_HOLD) begin
                serve_d  <= 1'b1;
                serve_wr <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // array access
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (state == MS_READY) begin
            blk_addr <= mi_req ? mi_addr : md_addr;
        end else if (state == MS_D_HOLD) begin
            blk_addr <= md_addr;
        end
        beat_data <= mem[{blk_addr, beat}];
        if (state == MS_D_WRITE) begin
            mem[{blk_addr, beat}] <= md_wblock[beat];
        end
    end

    a_single_ack: assert property (@(posedge clk) disable iff (!n_rst)
        !(mi_ack && md_ack));
    a_mi_ack_req: assert property (@(posedge clk) disable iff (!n_rst)
        $rose(mi_ack) |-> mi_req);
    a_md_ack_req: assert property (@(posedge clk) disable iff (!n_rst)
        $rose(md_ack) |-> md_req);

endmodule

// File: hdl/nand_cpu_pkg.sv
package nand_cpu_pkg;

    // ------------------------------------------------------------------
    // data types
    // ------------------------------------------------------------------

    // one data word, also the width of a memory beat
    typedef logic [31:0] word_t;

    // data port operation
    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } mem_op_t;

    // ------------------------------------------------------------------
    // state machines
    // ------------------------------------------------------------------

    // main memory
    typedef enum logic [2:0] {
        MS_READY,
        MS_I_READ,
        MS_D_WRITE,
        MS_D_HOLD,
        MS_D_READ,
        MS_RELEASE
    } mem_state_t;

    // both caches, icache never enters C_WRITEBACK
    typedef enum logic [1:0] {
        C_IDLE,
        C_WRITEBACK,
        C_REFILL,
        C_DONE
    } cache_state_t;

endpackage

// File: mem_init.hex
// one 32-bit word per line, word address 0x00 up to 0x3f, value c0de_AAAA with AA = address
c0de0000
c0de0101
c0de0202
c0de0303
c0de0404
c0de0505
c0de0606
c0de0707
c0de0808
c0de0909
c0de0a0a
c0de0b0b
c0de0c0c
c0de0d0d
c0de0e0e
c0de0f0f
c0de1010
c0de1111
c0de1212
c0de1313
c0de1414
c0de1515
c0de1616
c0de1717
c0de1818
c0de1919
c0de1a1a
c0de1b1b
c0de1c1c
c0de1d1d
c0de1e1e
c0de1f1f
c0de2020
c0de2121
c0de2222
c0de2323
c0de2424
c0de2525
c0de2626
c0de2727
c0de2828
c0de2929
c0de2a2a
c0de2b2b
c0de2c2c
c0de2d2d
c0de2e2e
c0de2f2f
c0de3030
c0de3131
c0de3232
c0de3333
c0de3434
c0de3535
c0de3636
c0de3737
c0de3838
c0de3939
c0de3a3a
c0de3b3b
c0de3c3c
c0de3d3d
c0de3e3e
c0de3f3f

// File: run_sim.sh
#!/bin/sh
# build the mem_subsystem testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module tb_mem_subsystem || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_mem_subsystem 2>&1)
echo "$out"
echo "$out" | grep -qx "Test completed successfully" && exit 0 || exit 1

// File: testbench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one table row, the expected words come from the shadow memory
typedef struct packed {
    logic                 use_f;
    logic [addr_bits-1:0] f_addr;
    logic                 use_d;
    mem_op_t              op;
    logic [addr_bits-1:0] d_addr;
    word_t                wdata;
    word_t                exp_f;
    word_t                exp_d;
} vector_t;

localparam int num_vectors = 21;

vector_t vectors [num_vectors];
int      vec_count = 0;
word_t   shadow [2**addr_bits];

task automatic add_vector(input logic use_f, input logic [addr_bits-1:0] f_addr,
                          input logic use_d, input mem_op_t op,
                          input logic [addr_bits-1:0] d_addr, input word_t wdata);
    vectors[vec_count] = '{use_f, f_addr, use_d, op, d_addr, wdata, 32'h0, 32'h0};
    vec_count++;
endtask

// ----------------------------------------------------------------------
// stimulus, fetches never touch a block that is stored to
// ----------------------------------------------------------------------

task automatic build_table();
    add_vector(1'b1, 6'h00, 1'b0, OP_LOAD,  6'h00, 32'h0);
    add_vector(1'b1, 6'h01, 1'b0, OP_LOAD,  6'h00, 32'h0);
    add_vector(1'b1, 6'h03, 1'b0, OP_LOAD,  6'h00, 32'h0);
    add_vector(1'b0, 6'h00, 1'b1, OP_LOAD,  6'h14, 32'h0);
    add_vector(1'b0, 6'h00, 1'b1, OP_LOAD,  6'h16, 32'h0);
    add_vector(1'b0, 6'h00, 1'b1, OP_STORE, 6'h15, 32'h12345678);
    add_vector(1'b0, 6'h00, 1'b1, OP_LOAD,  6'h15, 32'h0);
    add_vector(1'b0, 6'h00, 1'b1, OP_LOAD,  6'h17, 32'h0);
    // same line, other tag, so the dirty block goes back first
    add_vector(1'b0, 6'h00, 1'b1, OP_LOAD,  6'h25, 32'h0);
    add_vector(1'b0, 6'h00, 1'b1, OP_LOAD,  6'h15, 32'h0);
    add_vector(1'b1, 6'h08, 1'b1, OP_LOAD,  6'h30, 32'h0);
    add_vector(1'b1, 6'h09, 1'b1, OP_LOAD,  6'h31, 32'h0);
    // store miss, write-allocate
    add_vector(1'b0, 6'h00, 1'b1, OP_STORE, 6'h2a, 32'hdeadbeef);
    add_vector(1'b0, 6'h00, 1'b1, OP_LOAD,  6'h2b, 32'h0);
    add_vector(1'b0, 6'h00, 1'b1, OP_LOAD,  6'h2a, 32'h0);
    add_vector(1'b1, 6'h3c, 1'b1, OP_STORE, 6'h0e, 32'ha5a50f0f);
    add_vector(1'b0, 6'h00, 1'b1, OP_LOAD,  6'h0e, 32'h0);
    // fetch beside a dirty eviction
    add_vector(1'b1, 6'h18, 1'b1, OP_LOAD,  6'h1a, 32'h0);
    add_vector(1'b0, 6'h00, 1'b1, OP_LOAD,  6'h2a, 32'h0);
    add_vector(1'b1, 6'h0b, 1'b1, OP_LOAD,  6'h17, 32'h0);
    add_vector(1'b1, 6'h02, 1'b1, OP_LOAD,  6'h12, 32'h0);
endtask

// walk the table in order so stores reach later loads
task automatic fill_expected();
    $readmemh("mem_init.hex", shadow);
    for (int i = 0; i < vec_count; i++) begin
        if (vectors[i].use_f) begin
            vectors[i].exp_f = shadow[vectors[i].f_addr];
        end
        if (vectors[i].use_d && vectors[i].op == OP_STORE) begin
            shadow[vectors[i].d_addr] = vectors[i].wdata;
        end else if (vectors[i].use_d) begin
            vectors[i].exp_d = shadow[vectors[i].d_addr];
        end
    end
endtask

task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
        data_errors++;
        $display("ERR %0t: %s returned %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_ack(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        proto_errors++;
        $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

`endif

// File: testbench/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem
    import nand_cpu_pkg::*;
();

    localparam int addr_bits   = 6;
    localparam int block_words = 4;
    localparam int cache_lines = 4;

    logic                 clk;
    logic                 n_rst;
    logic                 if_req;
    logic [addr_bits-1:0] if_addr;
    logic                 if_ack;
    word_t                if_data;
    logic                 dc_req;
    mem_op_t              dc_op;
    logic [addr_bits-1:0] dc_addr;
    word_t                dc_wdata;
    logic                 dc_ack;
    word_t                dc_rdata;

    int   data_errors  = 0;
    int   proto_errors = 0;
    int   cycles       = 0;

    // monitor history from the last falling edge
    logic prev_if_req = 1'b0;
    logic prev_if_ack = 1'b0;
    logic prev_dc_req = 1'b0;
    logic prev_dc_ack = 1'b0;
    int   if_late     = 0;
    int   dc_late     = 0;

    `include "tb_vectors.svh"

    localparam int max_cycles = num_vectors * 40 + 100;

    mem_subsystem #(
        .addr_bits   (addr_bits),
        .block_words (block_words),
        .cache_lines (cache_lines)
    ) dut (
        .clk, .n_rst,
        .if_req, .if_addr, .if_ack, .if_data,
        .dc_req, .dc_op, .dc_addr, .dc_wdata, .dc_ack, .dc_rdata
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles with requests outstanding", cycles);
        $display("Test failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // table loop
    // ----------------------------------------------------------------------

    task automatic apply_vector(input int i);
        vector_t v;
        logic    f_wait;
        logic    d_wait;
        logic    f_seen;
        logic    d_seen;
        v        = vectors[i];
        f_wait   = v.use_f;
        d_wait   = v.use_d;
        f_seen   = 1'b0;
        d_seen   = 1'b0;
        if_req   = v.use_f;
        if_addr  = v.f_addr;
        dc_req   = v.use_d;
        dc_op    = v.op;
        dc_addr  = v.d_addr;
        dc_wdata = v.wdata;
        while (f_wait || d_wait) begin
            @(posedge clk);
            #1;
            // req stays up one cycle past ack, the monitor sees ack held
            if (f_wait && f_seen) begin
                if_req = 1'b0;
                f_wait = 1'b0;
            end else if (f_wait && if_ack) begin
                check_word($sformatf("vector %0d fetch %h", i, v.f_addr), if_data, v.exp_f);
                f_seen = 1'b1;
            end
            if (d_wait && d_seen) begin
                dc_req = 1'b0;
                d_wait = 1'b0;
            end else if (d_wait && dc_ack) begin
                if (v.op == OP_LOAD) begin
                    check_word($sformatf("vector %0d load %h", i, v.d_addr), dc_rdata, v.exp_d);
                end
                d_seen = 1'b1;
            end
        end
        while (if_ack || dc_ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        n_rst    = 1'b0;
        if_req   = 1'b0;
        if_addr  = '0;
        dc_req   = 1'b0;
        dc_op    = OP_LOAD;
        dc_addr  = '0;
        dc_wdata = '0;
        build_table();
        fill_expected();
        repeat (8) @(posedge clk);
        #1;
        n_rst = 1'b1;
        for (int i = 0; i < num_vectors; i++) begin
            apply_vector(i);
        end
        $display("data errors %0d, protocol errors %0d", data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // ----------------------------------------------------------------------
    // handshake monitor
    // ----------------------------------------------------------------------

    task automatic check_handshake(input string port, input logic ack, input logic last_req,
                                   input logic last_ack, input int late);
        if (!last_req && !last_ack) begin
            check_ack($sformatf("%s ack without req", port), ack, 1'b0);
        end
        if (last_req && last_ack) begin
            check_ack($sformatf("%s ack held while req high", port), ack, 1'b1);
        end
        if (late > 2) begin
            check_ack($sformatf("%s ack two cycles after req fell", port), ack, 1'b0);
        end
    endtask

    // falling edge, all signals settled
    always @(negedge clk) begin
        if (cycles > 0 && !n_rst) begin
            check_ack("if ack in reset", if_ack, 1'b0);
            check_ack("dc ack in reset", dc_ack, 1'b0);
        end else if (cycles > 0) begin
            if_late = (!if_req && if_ack) ? if_late + 1 : 0;
            dc_late = (!dc_req && dc_ack) ? dc_late + 1 : 0;
            check_handshake("if", if_ack, prev_if_req, prev_if_ack, if_late);
            check_handshake("dc", dc_ack, prev_dc_req, prev_dc_ack, dc_late);
            prev_if_req = if_req;
            prev_if_ack = if_ack;
            prev_dc_req = dc_req;
            prev_dc_ack = dc_ack;
        end
    end

endmodule

// File: vlog.f
+incdir+testbench
hdl/nand_cpu_pkg.sv
hdl/memory.sv
hdl/i_cache.sv
hdl/d_cache.sv
hdl/mem_subsystem.sv
testbench/tb_mem_subsystem.sv
